// ==== Bender.yml ====
package:
  name: trigger_xbar

sources:
  - verilog/trigger_xbar_pkg.sv
  - verilog/trigger_config_regs.sv
  - verilog/trigger_input_stage.sv
  - verilog/trigger_route.sv
  - verilog/trigger_xbar.sv
  - target: test
    files:
      - testbench/trigger_xbar_properties.sv
      - testbench/trigger_xbar_tb.sv

// ==== compile.f ====
verilog/trigger_xbar_pkg.sv
verilog/trigger_config_regs.sv
verilog/trigger_input_stage.sv
verilog/trigger_route.sv
verilog/trigger_xbar.sv
testbench/trigger_xbar_properties.sv
testbench/trigger_xbar_tb.sv

// ==== testbench/trigger_xbar_input.txt ====
# op name a b, all numbers hex
# W name addr data | R name addr expected | T name inputs outputs | P name {oe_bar,dirs} | X name count
R rst_out0 00 00000105
R rst_out4 04 00000005
R rst_out5 05 00000001
R rst_out8 08 00000000
R rst_ctrl 20 00000001
R rst_n_in 21 00000006
R rst_n_out 22 00000009
R rst_n_ext 23 00000004
R rst_version 3f 00010000
P rst_pins 1f
W route_d1 01 00000000
W route_d6 06 00000009
W route_d8 08 00000004
T route_all 3f 000001bf
T route_fanout 20 0000001d
T route_mix 13 00000122
T route_s3 0c 00000080
P route_pins 1d
R cur_out7 07 01000003
R cur_in3 13 01000000
W frc_in5 15 00030000
T frc_src 0c 0000009d
R frc_in5_rd 15 01030000
W frc_out7 07 00010003
W frc_out1 01 00030000
T frc_dst 0c 0000001f
W clr_in5 15 00000000
W clr_out7 07 00000003
W clr_out1 01 00000000
T clr_route 0c 00000080
W mask_15 0f ffffffff
R mask_15_rd 0f 00000000
W mask_22 16 ffffffff
R mask_22_rd 16 00000000
W mask_62 3e ffffffff
R mask_62_rd 3e 00000000
W mask_dir4 04 00000105
R mask_dir4_rd 04 00000005
W ctrl_oe 20 00000000
R ctrl_rd 20 00000000
P ctrl_pins 0d
X rand 14

// ==== testbench/trigger_xbar_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_xbar_properties #(
	parameter int N_EXTERNAL = 4
) (
	input wire logic                  clk,
	input wire logic                  reset,
	input wire logic                  reg_req,
	input wire logic                  reg_we,
	input wire logic                  reg_ack,
	input wire logic [N_EXTERNAL-1:0] trigger_dirs,
	input wire logic                  output_enable_bar
);

	logic seen_write;

	// number of assertion failures so far
	int failures = 0;

	// set once the first bus write is accepted
	always_ff @(posedge clk) begin
		if (reset) begin
			seen_write <= 1'b0;
		end else if (reg_req && reg_we && !reg_ack) begin
			seen_write <= 1'b1;
		end
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(reg_ack) |-> $past(reg_req))
		else begin
			$error("reg_ack rose without reg_req");
			failures++;
		end

	ack_drops_after_req: assert property (@(posedge clk) disable iff (reset)
		$fell(reg_req) && reg_ack |=> !reg_ack)
		else begin
			$error("reg_ack did not fall one cycle after reg_req");
			failures++;
		end

	// pins stay as inputs with the transceivers off
	idle_pins: assert property (@(posedge clk) disable iff (reset)
		!seen_write |-> output_enable_bar && (&trigger_dirs))
		else begin
			$error("pin direction or transceiver enable left reset state early");
			failures++;
		end

endmodule

`default_nettype wire

// ==== testbench/trigger_xbar_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_xbar_tb import trigger_xbar_pkg::*;;

	localparam int N_INPUTS   = 6;
	localparam int N_OUTPUTS  = 9;
	localparam int N_EXTERNAL = 4;

	logic                  clk = 1'b0;
	logic                  reset;
	logic [N_INPUTS-1:0]   trigger_inputs;
	logic [N_OUTPUTS-1:0]  trigger_outputs;
	logic [N_EXTERNAL-1:0] trigger_dirs;
	logic                  output_enable_bar;
	logic                  reg_req;
	logic                  reg_we;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_DATA_W-1:0] reg_wdata;
	logic                  reg_ack;
	logic [REG_DATA_W-1:0] reg_rdata;

	// operations read from the data file
	string       op_q[$];
	string       name_q[$];
	logic [31:0] arg_a_q[$];
	logic [31:0] arg_b_q[$];

	int          errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic        loaded;
	logic [31:0] rng_state;

	// shadow copy of the routing and force registers
	logic [SEL_W-1:0] sh_select [N_OUTPUTS];
	logic             sh_out_fe [N_OUTPUTS];
	logic             sh_out_fv [N_OUTPUTS];
	logic             sh_in_fe [N_INPUTS];
	logic             sh_in_fv [N_INPUTS];

	trigger_xbar #(
		.N_INPUTS(N_INPUTS),
		.N_OUTPUTS(N_OUTPUTS),
		.N_EXTERNAL(N_EXTERNAL)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.trigger_inputs(trigger_inputs),
		.trigger_outputs(trigger_outputs),
		.trigger_dirs(trigger_dirs),
		.output_enable_bar(output_enable_bar),
		.reg_req(reg_req),
		.reg_we(reg_we),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_ack(reg_ack),
		.reg_rdata(reg_rdata)
	);

	bind trigger_config_regs trigger_xbar_properties #(
		.N_EXTERNAL(N_EXTERNAL)
	) u_props (
		.clk(clk),
		.reset(reset),
		.reg_req(reg_req),
		.reg_we(reg_we),
		.reg_ack(reg_ack),
		.trigger_dirs(trigger_dirs),
		.output_enable_bar(output_enable_bar)
	);

	always #20 clk = ~clk;

	// run limit follows the length of the data file
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return {17'd0, rng_state[30:16]};
	endfunction

	// power-up routing of the board
	task automatic shadow_reset();
		for (int i = 0; i < N_OUTPUTS; i++) begin
			case (i)
				5: sh_select[i] = 4'd1;
				6: sh_select[i] = 4'd2;
				7: sh_select[i] = 4'd3;
				8: sh_select[i] = 4'd0;
				default: sh_select[i] = 4'd5;
			endcase
			sh_out_fe[i] = 1'b0;
			sh_out_fv[i] = 1'b0;
		end
		for (int j = 0; j < N_INPUTS; j++) begin
			sh_in_fe[j] = 1'b0;
			sh_in_fv[j] = 1'b0;
		end
	endtask

	task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data);
		if (addr < N_OUTPUTS) begin
			sh_select[addr] = data[FLD_SEL_LSB +: SEL_W];
			sh_out_fe[addr] = data[FLD_FORCE_EN];
			sh_out_fv[addr] = data[FLD_FORCE_VAL];
		end else if (addr >= ADDR_IN_BASE && addr < ADDR_IN_BASE + N_INPUTS) begin
			sh_in_fe[addr - ADDR_IN_BASE] = data[FLD_FORCE_EN];
			sh_in_fv[addr - ADDR_IN_BASE] = data[FLD_FORCE_VAL];
		end
	endtask

	function automatic logic [N_OUTPUTS-1:0] predict_outputs(input logic [N_INPUTS-1:0] pattern);
		logic [N_INPUTS-1:0]  src;
		logic [N_OUTPUTS-1:0] result;
		for (int j = 0; j < N_INPUTS; j++) begin
			src[j] = sh_in_fe[j] ? sh_in_fv[j] : pattern[j];
		end
		for (int i = 0; i < N_OUTPUTS; i++) begin
			if (sh_out_fe[i]) begin
				result[i] = sh_out_fv[i];
			end else if (sh_select[i] < N_INPUTS) begin
				result[i] = src[sh_select[i]];
			end else begin
				result[i] = 1'b0;
			end
		end
		return result;
	endfunction

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			$display("FAILED %0s expected %h actual %h", test_name, expected, actual);
			errors++;
		end
	endtask

	// one four-phase transfer, bounded waits on reg_ack
	task automatic bus_access(input string test_name, input logic we, input logic [31:0] addr,
			input logic [31:0] data, output logic [31:0] rdata);
		int waited;
		rdata = '0;
		@(posedge clk);
		reg_req   <= 1'b1;
		reg_we    <= we;
		reg_addr  <= addr[REG_ADDR_W-1:0];
		reg_wdata <= data;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!reg_ack && waited < 8);
		if (!reg_ack) begin
			$display("no reg_ack from the DUT in test %0s", test_name);
			errors++;
		end else begin
			rdata = reg_rdata;
		end
		@(posedge clk);
		reg_req <= 1'b0;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (reg_ack && waited < 8);
		if (reg_ack) begin
			$display("reg_ack stayed high after reg_req fell in test %0s", test_name);
			errors++;
		end
	endtask

	// 2 sync flops and the output register
	task automatic apply_pattern(input logic [N_INPUTS-1:0] pattern);
		@(posedge clk);
		trigger_inputs <= pattern;
		repeat (3) @(posedge clk);
		@(negedge clk);
	endtask

	task automatic random_routing(input string test_name, input logic [31:0] count);
		logic [31:0] dest;
		logic [31:0] sel;
		logic [31:0] pattern;
		logic [31:0] rdata;
		for (int k = 0; k < count; k++) begin
			dest    = next_rand() % N_OUTPUTS;
			sel     = next_rand() % 16;
			pattern = next_rand() % (1 << N_INPUTS);
			bus_access(test_name, 1'b1, dest, sel, rdata);
			shadow_write(dest, sel);
			apply_pattern(pattern[N_INPUTS-1:0]);
			check_value(test_name, 32'(predict_outputs(pattern[N_INPUTS-1:0])),
				32'(trigger_outputs));
		end
	endtask

	task automatic load_operations(output logic ok);
		int          fd;
		int          n;
		int          line_count;
		int          x_total;
		string       line;
		string       op;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		ok = 1'b0;
		line_count = 0;
		x_total = 0;
		fd = $fopen("testbench/trigger_xbar_input.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) == 0) break;
				line_count++;
				if (line.len() == 0 || line.getc(0) == "#") continue;
				b = '0;
				n = $sscanf(line, "%s %s %h %h", op, name, a, b);
				if (n < 3) continue;
				op_q.push_back(op);
				name_q.push_back(name);
				arg_a_q.push_back(a);
				arg_b_q.push_back(b);
				if (op == "X") x_total += a;
			end
			$fclose(fd);
			cycle_limit = line_count * 12 + x_total * 16 + 50;
			ok = 1'b1;
		end
	endtask

	task automatic run_operation(input int idx);
		int          errors_before;
		logic [31:0] rdata;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		name = name_q[idx];
		a = arg_a_q[idx];
		b = arg_b_q[idx];
		errors_before = errors;
		case (op_q[idx])
			"W": begin
				bus_access(name, 1'b1, a, b, rdata);
				shadow_write(a, b);
			end
			"R": begin
				bus_access(name, 1'b0, a, '0, rdata);
				check_value(name, b, rdata);
			end
			"T": begin
				apply_pattern(a[N_INPUTS-1:0]);
				check_value(name, b, 32'(trigger_outputs));
			end
			"P": check_value(name, a, 32'({output_enable_bar, trigger_dirs}));
			"X": random_routing(name, a);
			default: begin
				$display("unknown operation %0s in test %0s", op_q[idx], name);
				errors++;
			end
		endcase
		tests++;
		if (errors == errors_before) begin
			$display("%0s: pass", name);
		end else begin
			$display("%0s: fail", name);
		end
	endtask

	initial begin
		reset          <= 1'b1;
		reg_req        <= 1'b0;
		reg_we         <= 1'b0;
		reg_addr       <= '0;
		reg_wdata      <= '0;
		trigger_inputs <= '0;
		rng_state = 32'd20193;
		shadow_reset();
		load_operations(loaded);
		if (!loaded) begin
			$display("cannot open testbench/trigger_xbar_input.txt");
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (5) @(posedge clk);
			reset <= 1'b0;
			for (int i = 0; i < op_q.size(); i++) begin
				run_operation(i);
			end
			// failed bound assertions count as errors
			errors += u_dut.u_regs.u_props.failures;
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0) begin
				$display("TEST OK");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/trigger_config_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_config_regs import trigger_xbar_pkg::*; #(
	parameter int N_INPUTS   = 6,
	parameter int N_OUTPUTS  = 9,
	parameter int N_EXTERNAL = 4
) (
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic                                reg_req,
	input  wire logic                                reg_we,
	input  wire logic [REG_ADDR_W-1:0]               reg_addr,
	input  wire logic [REG_DATA_W-1:0]               reg_wdata,
	input  wire logic [N_INPUTS-1:0]                 src_value,
	input  wire logic [N_OUTPUTS-1:0]                trigger_outputs,
	output logic                                     reg_ack,
	output logic      [REG_DATA_W-1:0]               reg_rdata,
	output logic      [N_OUTPUTS-1:0][SEL_W-1:0]     out_select,
	output logic      [N_OUTPUTS-1:0]                out_force_en,
	output logic      [N_OUTPUTS-1:0]                out_force_val,
	output logic      [N_INPUTS-1:0]                 in_force_en,
	output logic      [N_INPUTS-1:0]                 in_force_val,
	output logic      [N_EXTERNAL-1:0]               trigger_dirs,
	output logic                                     output_enable_bar
);

	logic                  access;
	logic                  wr_en;
	logic                  rd_en;
	logic [REG_DATA_W-1:0] read_word;

	// counts must fit the register slots
	if (N_INPUTS > MAX_LINKS || N_OUTPUTS > MAX_LINKS) begin : g_count_check
		$error("trigger_config_regs: more links than register slots");
	end
	if (N_EXTERNAL > N_OUTPUTS) begin : g_ext_check
		$error("trigger_config_regs: N_EXTERNAL exceeds N_OUTPUTS");
	end

	// power-up routing of the tester board
	function automatic logic [SEL_W-1:0] default_select(input int dest);
		case (dest)
			0, 1, 2, 3, 4: return SEL_W'(5);
			5: return SEL_W'(1);
			6: return SEL_W'(2);
			7: return SEL_W'(3);
			default: return SEL_W'(0);
		endcase
	endfunction

	// new request seen while ack is still low
	assign access = reg_req && !reg_ack;
	assign wr_en  = access && reg_we;
	assign rd_en  = access && !reg_we;

	// four-phase slave, ack follows req by one edge
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_ack <= 1'b0;
		end else if (access) begin
			reg_ack <= 1'b1;
		end else if (!reg_req) begin
			reg_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			reg_rdata <= read_word;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_OUTPUTS; i++) begin
				out_select[i] <= default_select(i);
			end
			out_force_en      <= '0;
			out_force_val     <= '0;
			in_force_en       <= '0;
			in_force_val      <= '0;
			trigger_dirs      <= '1;
			output_enable_bar <= 1'b1;
		end else if (wr_en) begin
			for (int i = 0; i < N_OUTPUTS; i++) begin
				if (reg_addr == REG_ADDR_W'(ADDR_OUT_BASE + i)) begin
					out_select[i]    <= reg_wdata[FLD_SEL_LSB +: SEL_W];
					out_force_en[i]  <= reg_wdata[FLD_FORCE_EN];
					out_force_val[i] <= reg_wdata[FLD_FORCE_VAL];
				end
			end
			// only the external pins have a direction
			for (int i = 0; i < N_EXTERNAL; i++) begin
				if (reg_addr == REG_ADDR_W'(ADDR_OUT_BASE + i)) begin
					trigger_dirs[i] <= reg_wdata[FLD_DIR];
				end
			end
			for (int i = 0; i < N_INPUTS; i++) begin
				if (reg_addr == REG_ADDR_W'(ADDR_IN_BASE + i)) begin
					in_force_en[i]  <= reg_wdata[FLD_FORCE_EN];
					in_force_val[i] <= reg_wdata[FLD_FORCE_VAL];
				end
			end
			if (reg_addr == REG_ADDR_W'(ADDR_CTRL)) begin
				output_enable_bar <= reg_wdata[FLD_OE_BAR];
			end
		end
	end

	// readback word, unused addresses and bits stay 0
	always_comb begin
		read_word = '0;
		for (int i = 0; i < N_OUTPUTS; i++) begin
			if (reg_addr == REG_ADDR_W'(ADDR_OUT_BASE + i)) begin
				read_word[FLD_SEL_LSB +: SEL_W] = out_select[i];
				read_word[FLD_FORCE_EN]         = out_force_en[i];
				read_word[FLD_FORCE_VAL]        = out_force_val[i];
				read_word[FLD_CURRENT]          = trigger_outputs[i];
			end
		end
		for (int i = 0; i < N_EXTERNAL; i++) begin
			if (reg_addr == REG_ADDR_W'(ADDR_OUT_BASE + i)) begin
				read_word[FLD_DIR] = trigger_dirs[i];
			end
		end
		for (int i = 0; i < N_INPUTS; i++) begin
			if (reg_addr == REG_ADDR_W'(ADDR_IN_BASE + i)) begin
				read_word[FLD_FORCE_EN]  = in_force_en[i];
				read_word[FLD_FORCE_VAL] = in_force_val[i];
				read_word[FLD_CURRENT]   = src_value[i];
			end
		end
		case (reg_addr)
			REG_ADDR_W'(ADDR_CTRL):       read_word[FLD_OE_BAR] = output_enable_bar;
			REG_ADDR_W'(ADDR_N_INPUTS):   read_word = REG_DATA_W'(N_INPUTS);
			REG_ADDR_W'(ADDR_N_OUTPUTS):  read_word = REG_DATA_W'(N_OUTPUTS);
			REG_ADDR_W'(ADDR_N_EXTERNAL): read_word = REG_DATA_W'(N_EXTERNAL);
			REG_ADDR_W'(ADDR_VERSION):    read_word = BLOCK_VERSION;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/trigger_input_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_input_stage #(
	parameter int N_INPUTS = 6
) (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic [N_INPUTS-1:0] trigger_inputs,
	input  wire logic [N_INPUTS-1:0] in_force_en,
	input  wire logic [N_INPUTS-1:0] in_force_val,
	output logic      [N_INPUTS-1:0] src_value
);

	logic [N_INPUTS-1:0] sync_meta;
	logic [N_INPUTS-1:0] sync_q;

	// two flops per source, the sources are asynchronous
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= '0;
			sync_q    <= '0;
		end else begin
			sync_meta <= trigger_inputs;
			sync_q    <= sync_meta;
		end
	end

	// forced sources ignore the pin
	always_comb begin
		for (int i = 0; i < N_INPUTS; i++) begin
			if (in_force_en[i]) begin
				src_value[i] = in_force_val[i];
			end else begin
				src_value[i] = sync_q[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/trigger_route.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_route import trigger_xbar_pkg::*; #(
	parameter int N_INPUTS  = 6,
	parameter int N_OUTPUTS = 9
) (
	input  wire logic                            clk,
	input  wire logic                            reset,
	input  wire logic [N_INPUTS-1:0]             src_value,
	input  wire logic [N_OUTPUTS-1:0][SEL_W-1:0] out_select,
	input  wire logic [N_OUTPUTS-1:0]            out_force_en,
	input  wire logic [N_OUTPUTS-1:0]            out_force_val,
	output logic      [N_OUTPUTS-1:0]            trigger_outputs
);

	logic [N_OUTPUTS-1:0] route_next;

	// one mux per destination, a source may feed several of them
	always_comb begin
		for (int i = 0; i < N_OUTPUTS; i++) begin
			// selects past the last source give 0
			route_next[i] = 1'b0;
			for (int j = 0; j < N_INPUTS; j++) begin
				if (out_select[i] == SEL_W'(j)) begin
					route_next[i] = src_value[j];
				end
			end
			if (out_force_en[i]) begin
				route_next[i] = out_force_val[i];
			end
		end
	end

	// output register, last of the three stages
	always_ff @(posedge clk) begin
		if (reset) begin
			trigger_outputs <= '0;
		end else begin
			trigger_outputs <= route_next;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/trigger_xbar.sv ====
`timescale 1ns/1ns
`default_nettype none

module trigger_xbar import trigger_xbar_pkg::*; #(
	parameter int N_INPUTS   = 6,
	parameter int N_OUTPUTS  = 9,
	parameter int N_EXTERNAL = 4
) (
	input  wire logic                  clk,
	input  wire logic                  reset,
	input  wire logic [N_INPUTS-1:0]   trigger_inputs,
	output logic      [N_OUTPUTS-1:0]  trigger_outputs,
	output logic      [N_EXTERNAL-1:0] trigger_dirs,
	output logic                       output_enable_bar,
	input  wire logic                  reg_req,
	input  wire logic                  reg_we,
	input  wire logic [REG_ADDR_W-1:0] reg_addr,
	input  wire logic [REG_DATA_W-1:0] reg_wdata,
	output logic                       reg_ack,
	output logic      [REG_DATA_W-1:0] reg_rdata
);

	logic [N_INPUTS-1:0]             src_value;
	logic [N_INPUTS-1:0]             in_force_en;
	logic [N_INPUTS-1:0]             in_force_val;
	logic [N_OUTPUTS-1:0][SEL_W-1:0] out_select;
	logic [N_OUTPUTS-1:0]            out_force_en;
	logic [N_OUTPUTS-1:0]            out_force_val;

	trigger_config_regs #(
		.N_INPUTS(N_INPUTS),
		.N_OUTPUTS(N_OUTPUTS),
		.N_EXTERNAL(N_EXTERNAL)
	) u_regs (
		.clk(clk),
		.reset(reset),
		.reg_req(reg_req),
		.reg_we(reg_we),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.src_value(src_value),
		.trigger_outputs(trigger_outputs),
		.reg_ack(reg_ack),
		.reg_rdata(reg_rdata),
		.out_select(out_select),
		.out_force_en(out_force_en),
		.out_force_val(out_force_val),
		.in_force_en(in_force_en),
		.in_force_val(in_force_val),
		.trigger_dirs(trigger_dirs),
		.output_enable_bar(output_enable_bar)
	);

	// synchronized and possibly forced sources
	trigger_input_stage #(
		.N_INPUTS(N_INPUTS)
	) u_input (
		.clk(clk),
		.reset(reset),
		.trigger_inputs(trigger_inputs),
		.in_force_en(in_force_en),
		.in_force_val(in_force_val),
		.src_value(src_value)
	);

	trigger_route #(
		.N_INPUTS(N_INPUTS),
		.N_OUTPUTS(N_OUTPUTS)
	) u_route (
		.clk(clk),
		.reset(reset),
		.src_value(src_value),
		.out_select(out_select),
		.out_force_en(out_force_en),
		.out_force_val(out_force_val),
		.trigger_outputs(trigger_outputs)
	);

endmodule

`default_nettype wire

// ==== verilog/trigger_xbar_pkg.sv ====
`default_nettype none

package trigger_xbar_pkg;

	// register bus widths
	localparam int REG_ADDR_W = 6;
	localparam int REG_DATA_W = 32;

	// source select width and register slots per side
	localparam int SEL_W     = 4;
	localparam int MAX_LINKS = 16;

	// register map, word addresses
	localparam int ADDR_OUT_BASE   = 0;
	localparam int ADDR_IN_BASE    = 16;
	localparam int ADDR_CTRL       = 32;
	localparam int ADDR_N_INPUTS   = 33;
	localparam int ADDR_N_OUTPUTS  = 34;
	localparam int ADDR_N_EXTERNAL = 35;
	localparam int ADDR_VERSION    = 63;

	// field positions inside a link register
	localparam int FLD_SEL_LSB   = 0;
	localparam int FLD_DIR       = 8;
	localparam int FLD_FORCE_EN  = 16;
	localparam int FLD_FORCE_VAL = 17;
	localparam int FLD_CURRENT   = 24;

	// control register, transceiver enable (active low)
	localparam int FLD_OE_BAR = 0;

	// version 1.0.0 as 0001.00.00
	localparam logic [REG_DATA_W-1:0] BLOCK_VERSION = 32'h0001_0000;

endpackage

`default_nettype wire
